// File: flist.f
+incdir+.
exec_pkg.sv
pipe_delay.sv
alu.sv
mul_unit.sv
rob.sv
exec_core.sv
tb_exec_core.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_exec_core
FLIST = flist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: tb_exec_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_exec_core;

	localparam int NUM_OPS    = 400;
	localparam int MAX_CYCLES = NUM_OPS * (`MUL_STAGES + 2) + 100;

	logic              clk = 1'b0;
	logic              i_reset;
	logic              i_issue_valid;
	exec_pkg::issue_t  i_issue;
	logic              o_full;
	logic              o_commit_valid;
	exec_pkg::commit_t o_commit;

	integer seed         = 34101;
	int     cycle        = 0;     // Rising edges so far
	int     issued       = 0;
	int     model_count  = 0;     // Accepted issues minus observed commits
	int     value_errors = 0;
	int     other_errors = 0;

	exec_pkg::commit_t exp_q [$];
	logic              mul_q [$];
	int                due_q [$];  // Expected commit cycle, -1 when issued behind older ops

	exec_core exec_core_inst (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_issue_valid  (i_issue_valid),
		.i_issue        (i_issue),
		.o_full         (o_full),
		.o_commit_valid (o_commit_valid),
		.o_commit       (o_commit)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, %0d ops never committed", cycle, exp_q.size());
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// RISC-V R-type rules
	function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic [6:0] f7,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] fill;
		sh   = b[4:0];
		fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // Sign bits shifted in by sra
		case (f3)
			3'd0: alu_expect = (f7 == 7'h20) ? a - b : a + b;
			3'd1: alu_expect = a << sh;
			3'd2: alu_expect = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			3'd3: alu_expect = {31'b0, a < b};
			3'd4: alu_expect = a ^ b;
			3'd5: alu_expect = (f7 == 7'h20) ? ((a >> sh) | fill) : (a >> sh);
			3'd6: alu_expect = a | b;
			default: alu_expect = a & b;
		endcase
	endfunction

	task automatic drive_issue();
		logic [31:0]       r;
		exec_pkg::commit_t exp;
		r = $random(seed);
		i_issue.op_class = r[0] ? exec_pkg::OP_MUL : exec_pkg::OP_ALU;
		i_issue.funct3   = r[3:1];
		i_issue.funct7   = 7'h00;
		if (r[4] && (r[3:1] == 3'd0 || r[3:1] == 3'd5))
			i_issue.funct7 = 7'h20;  // sub and sra only
		i_issue.rd = r[9:5];
		i_issue.s1 = $random(seed);
		i_issue.s2 = $random(seed);
		exp.rd  = i_issue.rd;
		exp.tag = issued[`ROB_ENTRY_WIDTH-1:0];
		if (r[0])
			exp.value = i_issue.s1 * i_issue.s2;  // Low 32 bits of the product
		else
			exp.value = alu_expect(i_issue.funct3, i_issue.funct7, i_issue.s1, i_issue.s2);
		exp_q.push_back(exp);
		mul_q.push_back(r[0]);
		// Accepted at edge cycle+1
		due_q.push_back(model_count == 0 ? cycle + 1 + (r[0] ? `MUL_STAGES + 1 : 2) : -1);
		i_issue_valid = 1'b1;
		issued++;
		model_count++;
	endtask

	task automatic check_commit();
		exec_pkg::commit_t exp;
		logic              is_mul;
		int                due;
		assert (exp_q.size() != 0) else begin
			$display("Commit pulse at cycle %0d with no op outstanding", cycle);
			other_errors++;
		end
		if (exp_q.size() != 0) begin
			exp    = exp_q.pop_front();
			is_mul = mul_q.pop_front();
			due    = due_q.pop_front();
			assert (o_commit == exp) else begin
				$display("FAIL %s: expected rd %0d value %h tag %0d, actual rd %0d value %h tag %0d",
					is_mul ? "mul_result" : "alu_result", exp.rd, exp.value, exp.tag,
					o_commit.rd, o_commit.value, o_commit.tag);
				value_errors++;
			end
			if (due >= 0) begin
				assert (cycle == due) else begin
					$display("FAIL %s: expected commit at cycle %0d, actual %0d",
						is_mul ? "mul_latency" : "alu_latency", due, cycle);
					value_errors++;
				end
			end
		end
		model_count--;
	endtask

	task automatic check_idle();
		assert (!o_commit_valid && !o_full) else begin
			$display("FAIL reset_state: expected commit_valid 0 full 0, actual commit_valid %b full %b",
				o_commit_valid, o_full);
			value_errors++;
		end
	endtask

	initial begin
		i_reset       = 1'b1;
		i_issue_valid = 1'b0;
		i_issue       = '0;
		repeat (5) begin
			@(negedge clk);
			check_idle();
		end
		i_reset = 1'b0;
		@(negedge clk);
		check_idle();

		while (issued < NUM_OPS || exp_q.size() != 0) begin
			@(negedge clk);
			i_issue_valid = 1'b0;
			if (o_commit_valid)
				check_commit();
			assert (o_full == (model_count >= `ROB_ENTRIES)) else begin
				$display("FAIL fullness: expected %b, actual %b",
					model_count >= `ROB_ENTRIES, o_full);
				value_errors++;
			end
			if (issued < NUM_OPS && !o_full && ($unsigned($random(seed)) % 100) < 70)
				drive_issue();
		end

		$display("Errors: %0d value, %0d other, over %0d ops", value_errors, other_errors, issued);
		if (value_errors == 0 && other_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: exec_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module exec_core (
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_issue_valid,
	input  exec_pkg::issue_t  i_issue,
	output logic              o_full,
	output logic              o_commit_valid,
	output exec_pkg::commit_t o_commit
);

	exec_pkg::dispatch_t   dispatch;
	logic                  alu_valid;
	logic                  mul_valid;

	logic [`WORD_SIZE-1:0] alu_result;
	exec_pkg::wb_t         alu_wb_in;     // ALU result with its tag, before the register
	logic                  alu_wb_valid;
	exec_pkg::wb_t         alu_wb;

	logic                  mul_wb_valid;
	exec_pkg::wb_t         mul_wb;

	rob reorder_buffer (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_issue_valid  (i_issue_valid),
		.i_issue        (i_issue),
		.o_full         (o_full),
		.o_dispatch     (dispatch),
		.o_alu_valid    (alu_valid),
		.o_mul_valid    (mul_valid),
		.i_alu_wb_valid (alu_wb_valid),
		.i_alu_wb       (alu_wb),
		.i_mul_wb_valid (mul_wb_valid),
		.i_mul_wb       (mul_wb),
		.o_commit_valid (o_commit_valid),
		.o_commit       (o_commit)
	);

	alu int_alu (
		.i_funct3 (dispatch.funct3),
		.i_funct7 (dispatch.funct7),
		.i_s1     (dispatch.s1),
		.i_s2     (dispatch.s2),
		.o_result (alu_result)
	);

	assign alu_wb_in.value = alu_result;
	assign alu_wb_in.tag   = dispatch.tag;

	// One register between the ALU and its ROB write port
	pipe_delay #(
		.T     (exec_pkg::wb_t),
		.DEPTH (1)
	) alu_wb_delay (
		.clk     (clk),
		.i_reset (i_reset),
		.i_valid (alu_valid),
		.i_data  (alu_wb_in),
		.o_valid (alu_wb_valid),
		.o_data  (alu_wb)
	);

	mul_unit mul (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_valid    (mul_valid),
		.i_dispatch (dispatch),
		.o_wb_valid (mul_wb_valid),
		.o_wb       (mul_wb)
	);

endmodule

// File: rob.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module rob (
	input  logic                clk,
	input  logic                i_reset,
	// Issue from outside
	input  logic                i_issue_valid,
	input  exec_pkg::issue_t    i_issue,
	output logic                o_full,
	// Dispatch to the execution paths
	output exec_pkg::dispatch_t o_dispatch,
	output logic                o_alu_valid,
	output logic                o_mul_valid,
	// Write ports
	input  logic                i_alu_wb_valid,
	input  exec_pkg::wb_t       i_alu_wb,
	input  logic                i_mul_wb_valid,
	input  exec_pkg::wb_t       i_mul_wb,
	// In-order commit
	output logic                o_commit_valid,
	output exec_pkg::commit_t   o_commit
);

	localparam int ENTRIES = `ROB_ENTRIES;

	logic [`ROB_ENTRY_WIDTH-1:0] head_q;
	logic [`ROB_ENTRY_WIDTH-1:0] tail_q;
	logic [`ROB_ENTRY_WIDTH:0]   count_q;    // One extra bit to hold ENTRIES

	logic [ENTRIES-1:0] busy_q;
	logic [ENTRIES-1:0] done_q;
	logic [`ARCH_REG_INDEX_SIZE-1:0] rd_q    [ENTRIES];
	logic [`WORD_SIZE-1:0]           value_q [ENTRIES];

	logic issue_fire;
	logic retire;

	assign o_full     = (count_q == ENTRIES);
	assign issue_fire = i_issue_valid && !o_full;
	assign retire     = busy_q[head_q] && done_q[head_q];

	// New op goes out with the tail as its tag
	assign o_dispatch.funct3 = i_issue.funct3;
	assign o_dispatch.funct7 = i_issue.funct7;
	assign o_dispatch.s1     = i_issue.s1;
	assign o_dispatch.s2     = i_issue.s2;
	assign o_dispatch.tag    = tail_q;

	assign o_alu_valid = issue_fire && (i_issue.op_class == exec_pkg::OP_ALU);
	assign o_mul_valid = issue_fire && (i_issue.op_class == exec_pkg::OP_MUL);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			head_q         <= '0;
			tail_q         <= '0;
			count_q        <= '0;
			busy_q         <= '0;
			done_q         <= '0;
			o_commit_valid <= 1'b0;
		end else begin
			o_commit_valid <= retire;
			if (retire) begin
				busy_q[head_q] <= 1'b0;
				done_q[head_q] <= 1'b0;
				head_q         <= head_q + 1'b1;
			end
			// Tail equals head only when empty or full, so no clash with retire
			if (issue_fire) begin
				busy_q[tail_q] <= 1'b1;
				done_q[tail_q] <= 1'b0;
				tail_q         <= tail_q + 1'b1;
			end
			if (i_alu_wb_valid)
				done_q[i_alu_wb.tag] <= 1'b1;
			if (i_mul_wb_valid)
				done_q[i_mul_wb.tag] <= 1'b1;
			case ({issue_fire, retire})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_fire)
			rd_q[tail_q] <= i_issue.rd;
		if (i_alu_wb_valid)
			value_q[i_alu_wb.tag] <= i_alu_wb.value;
		if (i_mul_wb_valid)
			value_q[i_mul_wb.tag] <= i_mul_wb.value;
		if (retire) begin
			o_commit.rd    <= rd_q[head_q];
			o_commit.value <= value_q[head_q];
			o_commit.tag   <= head_q;
		end
	end

	// Results only land on entries that are still in flight
	a_alu_wb_busy: assert property (@(posedge clk) disable iff (i_reset)
		i_alu_wb_valid |-> busy_q[i_alu_wb.tag]);
	a_mul_wb_busy: assert property (@(posedge clk) disable iff (i_reset)
		i_mul_wb_valid |-> busy_q[i_mul_wb.tag]);

	a_count_max: assert property (@(posedge clk) disable iff (i_reset)
		count_q <= ENTRIES);

	// A tag lives in exactly one execution path
	a_wb_tags_differ: assert property (@(posedge clk) disable iff (i_reset)
		!(i_alu_wb_valid && i_mul_wb_valid && (i_alu_wb.tag == i_mul_wb.tag)));

endmodule

// File: mul_unit.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module mul_unit (
	input  logic                clk,
	input  logic                i_reset,
	input  logic                i_valid,
	input  exec_pkg::dispatch_t i_dispatch,
	output logic                o_wb_valid,
	output exec_pkg::wb_t       o_wb
);

	localparam int HALF = `WORD_SIZE / 2;

	logic [HALF-1:0] a_lo;
	logic [HALF-1:0] a_hi;
	logic [HALF-1:0] b_lo;
	logic [HALF-1:0] b_hi;

	// Stage one partial products
	logic                        s1_valid_q;
	logic [`WORD_SIZE-1:0]       pp_ll_q;
	logic [HALF-1:0]             pp_lh_q;     // Only low halves of the cross terms matter
	logic [HALF-1:0]             pp_hl_q;
	logic [`ROB_ENTRY_WIDTH-1:0] s1_tag_q;

	// Stage two low product
	logic          s2_valid_q;
	exec_pkg::wb_t s2_wb_q;

	assign a_lo = i_dispatch.s1[HALF-1:0];
	assign a_hi = i_dispatch.s1[`WORD_SIZE-1:HALF];
	assign b_lo = i_dispatch.s2[HALF-1:0];
	assign b_hi = i_dispatch.s2[`WORD_SIZE-1:HALF];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			s1_valid_q <= 1'b0;
			s2_valid_q <= 1'b0;
		end else begin
			s1_valid_q <= i_valid;
			s2_valid_q <= s1_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		pp_ll_q  <= `WORD_SIZE'(a_lo) * `WORD_SIZE'(b_lo);
		pp_lh_q  <= a_lo * b_hi;
		pp_hl_q  <= a_hi * b_lo;
		s1_tag_q <= i_dispatch.tag;

		s2_wb_q.value <= pp_ll_q + {pp_lh_q + pp_hl_q, {HALF{1'b0}}};
		s2_wb_q.tag   <= s1_tag_q;
	end

	// Remaining stages up to MUL_STAGES
	pipe_delay #(
		.T     (exec_pkg::wb_t),
		.DEPTH (`MUL_STAGES - 2)
	) tail_delay (
		.clk     (clk),
		.i_reset (i_reset),
		.i_valid (s2_valid_q),
		.i_data  (s2_wb_q),
		.o_valid (o_wb_valid),
		.o_data  (o_wb)
	);

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu (
	input  logic [2:0]            i_funct3,
	input  logic [6:0]            i_funct7,
	input  logic [`WORD_SIZE-1:0] i_s1,
	input  logic [`WORD_SIZE-1:0] i_s2,
	output logic [`WORD_SIZE-1:0] o_result
);

	localparam int SHAMT_W = $clog2(`WORD_SIZE);

	logic               alt;      // sub and sra
	logic [SHAMT_W-1:0] shamt;

	assign alt   = (i_funct7 == 7'b0100000);
	assign shamt = i_s2[SHAMT_W-1:0];

	always_comb begin
		case (i_funct3)
			3'b000: o_result = alt ? i_s1 - i_s2 : i_s1 + i_s2;
			3'b001: o_result = i_s1 << shamt;
			3'b010: o_result = {{(`WORD_SIZE-1){1'b0}}, $signed(i_s1) < $signed(i_s2)};
			3'b011: o_result = {{(`WORD_SIZE-1){1'b0}}, i_s1 < i_s2};
			3'b100: o_result = i_s1 ^ i_s2;
			3'b101: begin
				// Arithmetic shift keeps the sign bit
				if (alt)
					o_result = $signed(i_s1) >>> shamt;
				else
					o_result = i_s1 >> shamt;
			end
			3'b110: o_result = i_s1 | i_s2;
			default: o_result = i_s1 & i_s2;   // 3'b111
		endcase
	end

endmodule

// File: pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_valid,
	input  T     i_data,
	output logic o_valid,
	output T     o_data
);

	logic [DEPTH-1:0] valid_q;
	T                 data_q [DEPTH];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= i_valid;
			for (int i = 1; i < DEPTH; i++)
				valid_q[i] <= valid_q[i-1];
		end
	end

	// Payload just follows its valid bit down the chain
	always_ff @(posedge clk) begin
		data_q[0] <= i_data;
		for (int i = 1; i < DEPTH; i++)
			data_q[i] <= data_q[i-1];
	end

	assign o_valid = valid_q[DEPTH-1];
	assign o_data  = data_q[DEPTH-1];

	a_depth: assert property (@(posedge clk) DEPTH >= 1);

endmodule

// File: exec_pkg.sv
`include "core_cfg.svh"

package exec_pkg;

	// Selects the execution path
	typedef enum logic {
		OP_ALU = 1'b0,
		OP_MUL = 1'b1
	} op_class_e;

	// Decoded operation with its operand values
	typedef struct packed {
		op_class_e                       op_class;
		logic [2:0]                      funct3;
		logic [6:0]                      funct7;
		logic [`ARCH_REG_INDEX_SIZE-1:0] rd;
		logic [`WORD_SIZE-1:0]           s1;
		logic [`WORD_SIZE-1:0]           s2;
	} issue_t;

	// Operation sent to an execution path, tagged with its ROB entry
	typedef struct packed {
		logic [2:0]                  funct3;
		logic [6:0]                  funct7;
		logic [`WORD_SIZE-1:0]       s1;
		logic [`WORD_SIZE-1:0]       s2;
		logic [`ROB_ENTRY_WIDTH-1:0] tag;
	} dispatch_t;

	typedef struct packed {
		logic [`WORD_SIZE-1:0]       value;
		logic [`ROB_ENTRY_WIDTH-1:0] tag;
	} wb_t;

	typedef struct packed {
		logic [`ARCH_REG_INDEX_SIZE-1:0] rd;
		logic [`WORD_SIZE-1:0]           value;
		logic [`ROB_ENTRY_WIDTH-1:0]     tag;
	} commit_t;

endpackage

// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath widths
`define WORD_SIZE 32
`define ARCH_REG_INDEX_SIZE 5

// Reorder buffer depth, a power of two
`define ROB_ENTRIES 4
`define ROB_ENTRY_WIDTH 2     // log2 of ROB_ENTRIES

// Multiplier latency from issue edge to writeback edge
// Two product stages plus at least one delay stage, so 3 or more
`define MUL_STAGES 4

`endif
